// File: verilog/spim_pkg.sv
package spim_pkg;

	// ====================
	// register word offsets
	// ====================

	localparam logic [7:0] ctrl_addr    = 8'h00;
	localparam logic [7:0] cfg_addr     = 8'h04;
	localparam logic [7:0] txdata_addr  = 8'h08;
	localparam logic [7:0] rxdata_addr  = 8'h0C;
	localparam logic [7:0] status_addr  = 8'h10;
	localparam logic [7:0] int_en_addr  = 8'h14;
	localparam logic [7:0] int_sta_addr = 8'h18;

	// ctrl bit positions, bits 1 to 3 are pulses
	localparam int ctrl_enable_bit = 0;
	localparam int ctrl_update_bit = 1;
	localparam int ctrl_tx_clr_bit = 2;
	localparam int ctrl_rx_clr_bit = 3;

	// ====================
	// shared types
	// ====================

	// static engine config, clkdiv is the sclk half period (0 acts as 1)
	typedef struct packed {
		logic [7:0] clkdiv;
		logic [1:0] mode;
		logic       lsb_first;
	} spim_cfg_t;

	// one tx FIFO entry, last raises cs_n after this byte
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} tx_entry_t;

	// interrupt causes, same layout for INT_EN and INT_STA
	typedef struct packed {
		logic rx_ovf;
		logic byte_done;
	} int_sta_t;

	// mode 0, msb first, half period of one cycle
	localparam spim_cfg_t cfg_reset = '{clkdiv: 8'd1, mode: 2'd0, lsb_first: 1'b0};

endpackage

// File: verilog/spim_fifo.sv
module spim_fifo
#(
	parameter type payload_t = logic [7:0],
	parameter int fifo_depth = 16,
	localparam int cnt_w = $clog2(fifo_depth + 1),
	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1
)
(
	input  logic             reg_clk,
	input  logic             reg_rstn,
	input  logic             clear,
	input  logic             push,
	input  payload_t         push_data,
	input  logic             pop,
	output payload_t         head,
	output logic [cnt_w-1:0] count,
	output logic             full,
	output logic             empty
);

	payload_t         mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign full    = (count == cnt_w'(fifo_depth));
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// show-ahead
	assign head = mem[rd_ptr];

	always_ff @(posedge reg_clk)
	begin
		if (do_push && !clear)
			mem[wr_ptr] <= push_data;
	end

	// clear beats push and pop
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else if (clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	a_no_pop_empty: assert property (
		@(posedge reg_clk) disable iff (!reg_rstn)
		pop |-> !empty
	);

endmodule

// File: verilog/spim_shifter.sv
module spim_shifter
	import spim_pkg::*;
(
	input  logic       reg_clk,
	input  logic       reg_rstn,
	input  spim_cfg_t  cfg_active,
	input  logic       enable,

	// tx fifo handshake
	input  logic       tx_valid,
	input  tx_entry_t  tx_entry,
	output logic       tx_pop,

	// rx fifo
	output logic       rx_push,
	output logic [7:0] rx_byte,
	input  logic       rx_full,

	output logic       byte_done,
	output logic       rx_ovf,
	output logic       busy,

	// spi pins
	output logic       sclk,
	output logic       cs_n,
	output logic       mosi,
	input  logic       miso
);

	typedef enum logic [1:0] {st_idle, st_lead, st_shift, st_trail} state_t;

	state_t     state;
	logic [7:0] half;
	logic [7:0] div_cnt;
	logic [3:0] edge_cnt;
	logic [7:0] tx_sr;
	logic [7:0] rx_sr;
	logic       last_q;
	logic       cpol;
	logic       cpha;
	logic       lsb;
	logic       div_done;
	logic       start;
	logic       cont;
	logic       edge_now;
	logic       launch;
	logic       sample;

	function automatic logic bit_out(input logic [7:0] v, input logic lsb_first);
		return lsb_first ? v[0] : v[7];
	endfunction

	function automatic logic [7:0] shift_sr(input logic [7:0] v, input logic lsb_first);
		return lsb_first ? {1'b0, v[7:1]} : {v[6:0], 1'b0};
	endfunction

	assign cpol = cfg_active.mode[1];
	assign cpha = cfg_active.mode[0];
	assign lsb  = cfg_active.lsb_first;
	assign half = (cfg_active.clkdiv == 8'd0) ? 8'd1 : cfg_active.clkdiv;

	assign div_done = (div_cnt == half - 8'd1);
	assign start    = (state == st_idle) && enable && tx_valid;
	// back to back only when the previous byte was not last
	assign cont     = (state == st_trail) && div_done && !last_q && enable && tx_valid;
	assign tx_pop   = start || cont;
	assign busy     = (state != st_idle) || start;

	// edge_cnt counts edges already done, even means leading edge
	assign edge_now = ((state == st_lead) || (state == st_shift)) && div_done;
	assign launch   = cpha ? !edge_cnt[0] : (edge_cnt[0] && edge_cnt != 4'd15);
	assign sample   = cpha ? edge_cnt[0] : !edge_cnt[0];

	assign rx_byte = rx_sr;
	assign rx_ovf  = rx_push && rx_full;

	// ====================
	// control FSM
	// ====================

	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			state     <= st_idle;
			div_cnt   <= '0;
			edge_cnt  <= '0;
			sclk      <= cfg_reset.mode[1];
			cs_n      <= 1'b1;
			mosi      <= 1'b0;
			last_q    <= 1'b0;
			byte_done <= 1'b0;
			rx_push   <= 1'b0;
		end
		else
		begin
			byte_done <= 1'b0;
			rx_push   <= 1'b0;

			if (tx_pop)
				last_q <= tx_entry.last;
			// cpha 0 puts the first bit out before the leading edge
			if (tx_pop && !cpha)
				mosi <= bit_out(tx_entry.data, lsb);
			else if (edge_now && launch)
				mosi <= bit_out(tx_sr, lsb);

			case (state)
				st_idle:
				begin
					sclk    <= cpol;
					div_cnt <= '0;
					if (start)
					begin
						cs_n     <= 1'b0;
						edge_cnt <= '0;
						state    <= st_lead;
					end
				end
				st_lead, st_shift:
				begin
					if (div_done)
					begin
						div_cnt  <= '0;
						sclk     <= ~sclk;
						edge_cnt <= edge_cnt + 4'd1;
						if (edge_cnt == 4'd15)
						begin
							state     <= st_trail;
							byte_done <= 1'b1;
							rx_push   <= 1'b1;
						end
						else
							state <= st_shift;
					end
					else
						div_cnt <= div_cnt + 8'd1;
				end
				st_trail:
				begin
					if (div_done)
					begin
						div_cnt <= '0;
						if (cont)
						begin
							edge_cnt <= '0;
							state    <= st_lead;
						end
						else
						begin
							cs_n  <= 1'b1;
							state <= st_idle;
						end
					end
					else
						div_cnt <= div_cnt + 8'd1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// data shift registers
	always_ff @(posedge reg_clk)
	begin
		if (tx_pop)
			tx_sr <= cpha ? tx_entry.data : shift_sr(tx_entry.data, lsb);
		else if (edge_now && launch)
			tx_sr <= shift_sr(tx_sr, lsb);

		if (edge_now && sample)
			rx_sr <= lsb ? {miso, rx_sr[7:1]} : {rx_sr[6:0], miso};
	end

	a_idle_cs_high: assert property (
		@(posedge reg_clk) disable iff (!reg_rstn)
		(state == st_idle) |-> cs_n
	);

endmodule

// File: verilog/spim_regs_wrap.sv
module spim_regs_wrap
	import spim_pkg::*;
(
	input  logic      reg_clk,
	input  logic      reg_rstn,

	// from register file
	input  spim_cfg_t cfg_shadow,
	input  logic      update_req,
	input  logic      tx_clr_req,
	input  logic      rx_clr_req,

	// engine state
	input  logic      busy,

	output spim_cfg_t cfg_active,
	output logic      tx_clear,
	output logic      rx_clear
);

	logic upd_pending;
	logic apply;

	// ====================
	// config update
	// ====================

	// copy waits for an idle engine so a byte never changes mode midway
	assign apply = upd_pending && !busy;

	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			upd_pending <= 1'b0;
			cfg_active  <= cfg_reset;
		end
		else
		begin
			if (update_req)
				upd_pending <= 1'b1;
			else if (apply)
				upd_pending <= 1'b0;

			// latest shadow at the moment of the copy
			if (apply)
				cfg_active <= cfg_shadow;
		end
	end

	// one cycle clear pulses toward the fifos
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			tx_clear <= 1'b0;
			rx_clear <= 1'b0;
		end
		else
		begin
			tx_clear <= tx_clr_req;
			rx_clear <= rx_clr_req;
		end
	end

	a_cfg_stable_busy: assert property (
		@(posedge reg_clk) disable iff (!reg_rstn)
		busy |=> $stable(cfg_active)
	);

endmodule

// File: verilog/spim_apb_regs.sv
module spim_apb_regs
	import spim_pkg::*;
#(
	parameter int fifo_depth = 16,
	localparam int cnt_w = $clog2(fifo_depth + 1)
)
(
	input  logic              reg_clk,
	input  logic              reg_rstn,

	// apb slave, no wait states
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [31:0]       paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,

	// config and control strobes
	output spim_cfg_t         cfg_shadow,
	output logic              enable,
	output logic              update_req,
	output logic              tx_clr_req,
	output logic              rx_clr_req,

	// fifo side
	output logic              tx_push,
	output tx_entry_t         tx_entry,
	input  logic [cnt_w-1:0]  tx_count,
	output logic              rx_pop,
	input  logic [7:0]        rx_head,
	input  logic [cnt_w-1:0]  rx_count,

	// engine status and interrupts
	input  logic              busy,
	input  logic              byte_done,
	input  logic              rx_ovf,
	output int_sta_t          int_en,
	output int_sta_t          int_sta
);

	logic     wr_en;
	logic     rd_en;
	logic     sel_ctrl;
	logic     sel_cfg;
	logic     sel_txdata;
	logic     sel_rxdata;
	logic     sel_status;
	logic     sel_int_en;
	logic     sel_int_sta;
	logic     rx_has_data;
	logic [1:0] sta_clr;
	int_sta_t sta_set;

	assign wr_en = psel && penable && pwrite;
	assign rd_en = psel && penable && !pwrite;

	assign sel_ctrl    = (paddr == {24'h0, ctrl_addr});
	assign sel_cfg     = (paddr == {24'h0, cfg_addr});
	assign sel_txdata  = (paddr == {24'h0, txdata_addr});
	assign sel_rxdata  = (paddr == {24'h0, rxdata_addr});
	assign sel_status  = (paddr == {24'h0, status_addr});
	assign sel_int_en  = (paddr == {24'h0, int_en_addr});
	assign sel_int_sta = (paddr == {24'h0, int_sta_addr});

	assign rx_has_data = (rx_count != '0);

	// ====================
	// strobes
	// ====================

	assign update_req = wr_en && sel_ctrl && pwdata[ctrl_update_bit];
	assign tx_clr_req = wr_en && sel_ctrl && pwdata[ctrl_tx_clr_bit];
	assign rx_clr_req = wr_en && sel_ctrl && pwdata[ctrl_rx_clr_bit];

	// full fifo drops the write on its own
	assign tx_push  = wr_en && sel_txdata;
	assign tx_entry = '{data: pwdata[7:0], last: pwdata[8]};

	assign rx_pop = rd_en && sel_rxdata && rx_has_data;

	// ====================
	// storage
	// ====================

	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			cfg_shadow <= cfg_reset;
			enable     <= 1'b0;
			int_en     <= '0;
		end
		else if (wr_en)
		begin
			if (sel_cfg)
				cfg_shadow <= spim_cfg_t'(pwdata[$bits(spim_cfg_t)-1:0]);
			if (sel_ctrl)
				enable <= pwdata[ctrl_enable_bit];
			if (sel_int_en)
				int_en <= int_sta_t'(pwdata[1:0]);
		end
	end

	// write one to clear, a new event wins
	assign sta_set = '{rx_ovf: rx_ovf, byte_done: byte_done};
	assign sta_clr = (wr_en && sel_int_sta) ? pwdata[1:0] : 2'b00;

	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
			int_sta <= '0;
		else
			int_sta <= (int_sta & ~sta_clr) | sta_set;
	end

	// read mux, ctrl is write only
	always_comb
	begin
		prdata = '0;
		if (rd_en)
		begin
			if (sel_cfg)
				prdata[$bits(spim_cfg_t)-1:0] = cfg_shadow;
			else if (sel_rxdata && rx_has_data)
				prdata[7:0] = rx_head;
			else if (sel_status)
			begin
				prdata[cnt_w-1:0]   = tx_count;
				prdata[8 +: cnt_w]  = rx_count;
				prdata[16]          = busy;
			end
			else if (sel_int_en)
				prdata[1:0] = int_en;
			else if (sel_int_sta)
				prdata[1:0] = int_sta;
		end
	end

	a_access_has_psel: assert property (
		@(posedge reg_clk) disable iff (!reg_rstn)
		penable |-> psel
	);

endmodule

// File: verilog/spim_top.sv
module spim_top
	import spim_pkg::*;
#(
	parameter int fifo_depth = 16
)
(
	input  logic        reg_clk,
	input  logic        reg_rstn,

	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,

	output logic        sclk,
	output logic        cs_n,
	output logic        mosi,
	input  logic        miso,
	output logic        irq
);

	localparam int cnt_w = $clog2(fifo_depth + 1);

	spim_cfg_t        cfg_shadow;
	spim_cfg_t        cfg_active;
	logic             enable;
	logic             update_req;
	logic             tx_clr_req;
	logic             rx_clr_req;
	logic             tx_clear;
	logic             rx_clear;
	logic             tx_push;
	tx_entry_t        tx_wr_entry;
	tx_entry_t        tx_head;
	logic [cnt_w-1:0] tx_count;
	logic             tx_empty;
	logic             tx_pop;
	logic             rx_push;
	logic [7:0]       rx_byte;
	logic [7:0]       rx_head;
	logic [cnt_w-1:0] rx_count;
	logic             rx_full;
	logic             rx_pop;
	logic             busy;
	logic             byte_done;
	logic             rx_ovf;
	int_sta_t         int_en;
	int_sta_t         int_sta;

	spim_apb_regs #(.fifo_depth(fifo_depth)) spim_apb_regs_inst (.*, .tx_entry(tx_wr_entry));

	spim_regs_wrap spim_regs_wrap_inst (.*);

	spim_fifo #(.payload_t(tx_entry_t), .fifo_depth(fifo_depth)) tx_fifo_inst (
		.reg_clk(reg_clk), .reg_rstn(reg_rstn), .clear(tx_clear),
		.push(tx_push), .push_data(tx_wr_entry), .pop(tx_pop),
		.head(tx_head), .count(tx_count), .full(), .empty(tx_empty)
	);

	spim_fifo #(.payload_t(logic [7:0]), .fifo_depth(fifo_depth)) rx_fifo_inst (
		.reg_clk(reg_clk), .reg_rstn(reg_rstn), .clear(rx_clear),
		.push(rx_push), .push_data(rx_byte), .pop(rx_pop),
		.head(rx_head), .count(rx_count), .full(rx_full), .empty()
	);

	spim_shifter spim_shifter_inst (.*, .tx_valid(!tx_empty), .tx_entry(tx_head));

	// status gated by enables
	assign irq = |(int_sta & int_en);

endmodule

// File: dv/spim_tb.sv
module spim_tb
	import spim_pkg::*;
();

	localparam int fifo_depth = 16;
	// bytes over all tests, budgeted at the slowest half period used
	localparam int test_bytes = 39;
	localparam int h_max = 4;
	localparam int timeout_cycles = test_bytes * (18 * h_max + 8) + 3000;

	logic        reg_clk;
	logic        reg_rstn;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        sclk;
	logic        cs_n;
	logic        mosi;
	logic        miso;
	logic        irq;

	// loopback mux
	logic        miso_force;
	logic        miso_value;

	// mosi monitor state
	logic [1:0]  mon_mode;
	logic        mon_lsb;
	logic [7:0]  mon_sr;
	int          mon_cnt;
	int          mon_total;
	logic [7:0]  mon_q [$];
	int          rise_q [$];
	logic        sclk_q;
	logic        cs_n_q;

	int          checks;
	int          errors;
	int          cycles;
	logic [31:0] lfsr;

	assign miso = miso_force ? miso_value : mosi;

	spim_top #(.fifo_depth(fifo_depth)) spim_top_inst (
		.reg_clk(reg_clk), .reg_rstn(reg_rstn),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso), .irq(irq)
	);

	always #5 reg_clk = ~reg_clk;

	// ====================
	// checks and helpers
	// ====================

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("ERROR at %0t: %s", $time, what);
		end
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] cfg_word(input logic [7:0] clkdiv, input logic [1:0] mode,
		input logic lsb);
		return {21'h0, clkdiv, mode, lsb};
	endfunction

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge reg_clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = {24'h0, addr};
		pwdata = data;
		@(negedge reg_clk);
		penable = 1'b1;
		@(negedge reg_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge reg_clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = {24'h0, addr};
		@(negedge reg_clk);
		penable = 1'b1;
		// prdata is combinational, settled well before the pop edge
		#1;
		data = prdata;
		@(negedge reg_clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// shadow write, then update with enable set
	task automatic configure(input logic [7:0] clkdiv, input logic [1:0] mode, input logic lsb);
		apb_write(cfg_addr, cfg_word(clkdiv, mode, lsb));
		apb_write(ctrl_addr, 32'h3);
		mon_mode = mode;
		mon_lsb = lsb;
		repeat (2) @(negedge reg_clk);
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		st = 32'h0001_0000;
		while (st[16] || st[4:0] != 5'd0)
			apb_read(status_addr, st);
	endtask

	task automatic expect_byte(input logic [7:0] exp);
		logic [31:0] rd;
		check_true(mon_q.size() != 0, "no byte was seen on mosi");
		if (mon_q.size() != 0)
			check_eq("mosi byte", {24'h0, exp}, {24'h0, mon_q.pop_front()});
		apb_read(rxdata_addr, rd);
		check_eq("RXDATA", {24'h0, exp}, rd);
	endtask

	task automatic send_and_check(input int n);
		logic [7:0] sent [$];
		logic [7:0] b;
		for (int i = 0; i < n; i++)
		begin
			random_byte(b);
			sent.push_back(b);
			apb_write(txdata_addr, {24'h0, b});
		end
		wait_idle();
		foreach (sent[i])
			expect_byte(sent[i]);
	endtask

	// ====================
	// monitor
	// ====================

	// sample level is high for modes 0 and 3
	always @(negedge reg_clk)
	begin
		if (reg_rstn)
		begin
			if (cs_n)
				mon_cnt = 0;
			else if (sclk != sclk_q && sclk == !(mon_mode[1] ^ mon_mode[0]))
			begin
				mon_sr = mon_lsb ? {mosi, mon_sr[7:1]} : {mon_sr[6:0], mosi};
				mon_cnt++;
				if (mon_cnt == 8)
				begin
					mon_q.push_back(mon_sr);
					mon_total++;
					mon_cnt = 0;
				end
			end
			if (cs_n && !cs_n_q)
				rise_q.push_back(mon_total);
		end
		sclk_q = sclk;
		cs_n_q = cs_n;
	end

	always @(posedge reg_clk)
	begin
		cycles++;
		if (cycles >= timeout_cycles)
		begin
			$display("timeout after %0d cycles, the DUT never went idle", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ====================
	// directed tests
	// ====================

	task automatic reset_and_registers();
		logic [31:0] rd;
		check_eq("cs_n", 1, cs_n);
		check_eq("irq", 0, irq);
		check_eq("sclk", 0, sclk);
		check_eq("mosi", 0, mosi);
		apb_read(status_addr, rd);
		check_eq("STATUS", 0, rd);
		apb_read(cfg_addr, rd);
		check_eq("CFG after reset", cfg_word(8'd1, 2'd0, 1'b0), rd);
		apb_write(cfg_addr, cfg_word(8'hA5, 2'd2, 1'b1));
		apb_read(cfg_addr, rd);
		check_eq("CFG", cfg_word(8'hA5, 2'd2, 1'b1), rd);
		apb_write(cfg_addr, cfg_word(8'h3C, 2'd1, 1'b0));
		apb_read(cfg_addr, rd);
		check_eq("CFG", cfg_word(8'h3C, 2'd1, 1'b0), rd);
		apb_write(ctrl_addr, 32'hF);
		apb_read(ctrl_addr, rd);
		check_eq("CTRL", 0, rd);
	endtask

	task automatic loopback_all_modes();
		mon_q.delete();
		for (int m = 0; m < 4; m++)
		begin
			for (int l = 0; l < 2; l++)
			begin
				configure(8'(m + 1), 2'(m), 1'(l));
				check_eq("sclk idle", {31'h0, m[1]}, {31'h0, sclk});
				check_eq("cs_n", 1, cs_n);
				send_and_check(2);
				check_eq("sclk idle after bytes", {31'h0, m[1]}, {31'h0, sclk});
			end
		end
	endtask

	// mode 2 idles high, so a leaked shadow shows on sclk
	task automatic shadow_config_rule();
		configure(8'd2, 2'd0, 1'b0);
		apb_write(cfg_addr, cfg_word(8'd2, 2'd2, 1'b0));
		send_and_check(1);
		check_eq("sclk idle, old mode", 0, sclk);
		apb_write(ctrl_addr, 32'h3);
		mon_mode = 2'd2;
		repeat (2) @(negedge reg_clk);
		check_eq("sclk idle, new mode", 1, sclk);
		send_and_check(1);
	endtask

	task automatic chip_select_framing();
		logic [7:0] b [3];
		int base;
		configure(8'd1, 2'd1, 1'b0);
		apb_write(ctrl_addr, 32'h0);
		for (int i = 0; i < 3; i++)
		begin
			random_byte(b[i]);
			// second byte carries last
			apb_write(txdata_addr, {23'h0, i == 1, b[i]});
		end
		base = mon_total;
		rise_q.delete();
		apb_write(ctrl_addr, 32'h1);
		wait_idle();
		check_eq("cs_n rise count", 2, rise_q.size());
		if (rise_q.size() == 2)
		begin
			check_eq("bytes before first cs_n rise", base + 2, rise_q[0]);
			check_eq("bytes before second cs_n rise", base + 3, rise_q[1]);
		end
		for (int i = 0; i < 3; i++)
			expect_byte(b[i]);
	endtask

	task automatic fifo_limits_and_clears();
		logic [31:0] rd;
		configure(8'd1, 2'd0, 1'b0);
		apb_write(ctrl_addr, 32'h0);
		for (int i = 0; i < fifo_depth + 2; i++)
			apb_write(txdata_addr, i);
		apb_read(status_addr, rd);
		check_eq("tx count", fifo_depth, {27'h0, rd[4:0]});
		apb_write(ctrl_addr, 32'h4);
		apb_read(status_addr, rd);
		check_eq("tx count after clear", 0, {27'h0, rd[4:0]});
		apb_write(ctrl_addr, 32'h8);
		apb_read(rxdata_addr, rd);
		check_eq("RXDATA when empty", 0, rd);

		// overfill rx with miso held high
		apb_write(int_sta_addr, 32'h3);
		miso_force = 1'b1;
		miso_value = 1'b1;
		apb_write(ctrl_addr, 32'h1);
		for (int i = 0; i < fifo_depth + 1; i++)
			apb_write(txdata_addr, i);
		wait_idle();
		apb_read(status_addr, rd);
		check_eq("rx count", fifo_depth, {27'h0, rd[12:8]});
		apb_read(int_sta_addr, rd);
		check_eq("INT_STA rx_ovf", 1, {31'h0, rd[1]});
		apb_read(rxdata_addr, rd);
		check_eq("RXDATA forced miso", 32'hFF, rd);
		apb_write(ctrl_addr, 32'h9);
		apb_read(status_addr, rd);
		check_eq("rx count after clear", 0, {27'h0, rd[12:8]});
		miso_force = 1'b0;
		mon_q.delete();
	endtask

	task automatic interrupt_gating();
		logic [31:0] rd;
		configure(8'd1, 2'd0, 1'b0);
		apb_write(int_en_addr, 32'h0);
		apb_write(int_sta_addr, 32'h3);
		send_and_check(1);
		apb_read(int_sta_addr, rd);
		check_eq("INT_STA", 1, rd);
		check_eq("irq, enables off", 0, irq);
		apb_write(int_en_addr, 32'h1);
		check_eq("irq, byte_done enabled", 1, irq);
		apb_write(int_en_addr, 32'h2);
		check_eq("irq, only rx_ovf enabled", 0, irq);
		apb_write(int_en_addr, 32'h3);
		apb_write(int_sta_addr, 32'h1);
		check_eq("irq after clear", 0, irq);
		apb_read(int_sta_addr, rd);
		check_eq("INT_STA after clear", 0, rd);
	endtask

	initial
	begin
		reg_clk = 1'b0;
		reg_rstn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		miso_force = 1'b0;
		miso_value = 1'b0;
		mon_mode = 2'd0;
		mon_lsb = 1'b0;
		mon_sr = '0;
		mon_cnt = 0;
		mon_total = 0;
		sclk_q = 1'b0;
		cs_n_q = 1'b1;
		checks = 0;
		errors = 0;
		cycles = 0;
		lfsr = 32'd32;
		repeat (16) @(negedge reg_clk);
		reg_rstn = 1'b1;
		repeat (2) @(negedge reg_clk);

		reset_and_registers();
		loopback_all_modes();
		shadow_config_rule();
		chip_select_framing();
		fifo_limits_and_clears();
		interrupt_gating();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: files.f
verilog/spim_pkg.sv
verilog/spim_fifo.sv
verilog/spim_shifter.sv
verilog/spim_regs_wrap.sv
verilog/spim_apb_regs.sv
verilog/spim_top.sv
dv/spim_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the spim testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module spim_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vspim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
exit 0
